// ==== Makefile ====
# Verilator build and run of the wfg_pattern testbench

SRCS := $(wildcard include/*.svh logic/*.sv tests/*.sv)

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_wfg_top: wfg_pattern.f $(SRCS)
	verilator --binary --timing -f wfg_pattern.f --top-module tb_wfg_top -o Vtb_wfg_top

# The log decides pass or fail
run: obj_dir/Vtb_wfg_top
	-obj_dir/Vtb_wfg_top > sim.log 2>&1
	cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== include/wfg_cfg.svh ====
`ifndef WFG_CFG_SVH
`define WFG_CFG_SVH

// ------------------------------------------------------------
// Build-time sizing of the pattern generator
// ------------------------------------------------------------

// Number of pattern output channels, one pin each
`define WFG_CHANNELS 8

// AXI-Stream word width, one word per period
`define WFG_AXIS_WIDTH 32

// Subcycle numbers and prescaler counts
`define WFG_SUB_W 8

// Bits per channel pattern code
`define WFG_PAT_SEL_W 2

`endif

// ==== logic/wfg_core.sv ====
`timescale 1ns/1ps

module wfg_core (
    input  logic                 clk,       // System clock
    input  logic                 rst_n,     // Async reset, active low
    input  wfg_pkg::wfg_core_cfg_t cfg_i,   // Enable and period shape
    output wfg_pkg::wfg_timing_t   timing_o // Sync pulse and subcycle number
);

    import wfg_pkg::*;

    // ------------------------------------------------------------
    // State
    // ------------------------------------------------------------

    core_state_e state_q;
    sub_len_t    presc_q;   // Clock within subcycle
    subcycle_t   sub_q;     // Subcycle within period
    logic        sync_q;    // Registered period start

    logic presc_wrap;       // Last clock of a subcycle
    logic period_wrap;      // Last clock of a period

    // >= so a shrinking config cannot strand the counters
    assign presc_wrap  = (presc_q >= cfg_i.sub_len);
    assign period_wrap = presc_wrap && (sub_q >= cfg_i.last_sub);

    // ------------------------------------------------------------
    // Control and counters
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= CORE_IDLE;
            presc_q <= '0;
            sub_q   <= '0;
            sync_q  <= 1'b0;
        end else begin
            case (state_q)
                CORE_IDLE: begin
                    // Counters parked so the first period is aligned
                    presc_q <= '0;
                    sub_q   <= '0;
                    if (cfg_i.en) begin
                        state_q <= CORE_RUN;
                        sync_q  <= 1'b1;  // First period starts next clock
                    end else begin
                        sync_q  <= 1'b0;
                    end
                end

                CORE_RUN: begin
                    if (!cfg_i.en) begin
                        // Stop immediately, no period completion
                        state_q <= CORE_IDLE;
                        presc_q <= '0;
                        sub_q   <= '0;
                        sync_q  <= 1'b0;
                    end else begin
                        sync_q <= period_wrap;  // Pulse on wrap to subcycle 0
                        if (presc_wrap) begin
                            presc_q <= '0;
                            if (period_wrap) begin
                                sub_q <= '0;
                            end else begin
                                sub_q <= sub_q + subcycle_t'(1);
                            end
                        end else begin
                            presc_q <= presc_q + sub_len_t'(1);
                        end
                    end
                end

                default: begin
                    state_q <= CORE_IDLE;
                    presc_q <= '0;
                    sub_q   <= '0;
                    sync_q  <= 1'b0;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------

    assign timing_o.sync         = sync_q;
    assign timing_o.subcycle_cnt = sub_q;  // Zero while idle

endmodule

// ==== logic/wfg_drive_pat.sv ====
`timescale 1ns/1ps

`include "wfg_cfg.svh"

module wfg_drive_pat (
    input  logic                  clk,            // System clock
    input  logic                  rst_n,          // Async reset, active low
    input  wfg_pkg::wfg_timing_t  timing_i,       // Sync and subcycle from core
    input  wfg_pkg::wfg_pat_cfg_t pat_cfg_i,      // Enables, codes, window
    input  wfg_pkg::axis_in_t     axis_i,         // Stream valid and data
    output logic                  axis_tready_o,  // Stream ready
    output wfg_pkg::chan_vec_t    pat_dout_o,     // Pin levels
    output wfg_pkg::chan_vec_t    pat_dout_en_o   // Pin enables
);

    import wfg_pkg::*;

    // ------------------------------------------------------------
    // Stream capture
    // ------------------------------------------------------------

    axis_data_t data_q;     // Word of the current period
    axis_data_t data_eff;   // Word the channels see this clock
    logic       accept;     // Transfer at the coming edge

    // Only back-pressure is waiting for the next sync
    assign axis_tready_o = timing_i.sync;
    assign accept        = axis_tready_o && axis_i.tvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (accept) begin
            data_q <= axis_i.tdata;
        end
        // No valid at sync, old word is reused
    end

    // Bypass so the pin register already evaluates the new word
    // while it is being accepted; subcycle 0 then shows it from
    // its second clock on
    assign data_eff = accept ? axis_i.tdata : data_q;

    // Enables pass straight through
    assign pat_dout_en_o = pat_cfg_i.ctrl_en;

    // ------------------------------------------------------------
    // Channels
    // ------------------------------------------------------------

    genvar k;
    generate
        for (k = 0; k < `WFG_CHANNELS; k++) begin : gen_channels
            wfg_drive_pat_channel chan_i (
                .clk         (clk),
                .rst_n       (rst_n),
                .subcycle_i  (timing_i.subcycle_cnt),  // Shared by all pins
                .win_begin_i (pat_cfg_i.win_begin),
                .win_end_i   (pat_cfg_i.win_end),
                .pat_sel_i   (pat_cfg_i.patsel[k]),
                .en_i        (pat_cfg_i.ctrl_en[k]),
                .data_bit_i  (data_eff[k]),            // Low bits of the word
                .dout_o      (pat_dout_o[k])
            );
        end
    endgenerate

endmodule

// ==== logic/wfg_drive_pat_channel.sv ====
`timescale 1ns/1ps

module wfg_drive_pat_channel (
    input  logic                clk,          // System clock
    input  logic                rst_n,        // Async reset, active low
    input  wfg_pkg::subcycle_t  subcycle_i,   // Current subcycle
    input  wfg_pkg::subcycle_t  win_begin_i,  // Window start, inclusive
    input  wfg_pkg::subcycle_t  win_end_i,    // Window end, exclusive
    input  wfg_pkg::pat_sel_t   pat_sel_i,    // Pattern code for this pin
    input  logic                en_i,         // Pin enable
    input  logic                data_bit_i,   // This channel's stream bit
    output logic                dout_o        // Registered pin level
);

    import wfg_pkg::*;

    logic in_win;   // Subcycle lies in [begin, end)
    logic pin_d;    // Next pin level before enable
    logic dout_q;

    // ------------------------------------------------------------
    // Window compare
    // ------------------------------------------------------------

    // Empty when begin >= end, the two terms can never both hold
    assign in_win = (subcycle_i >= win_begin_i) && (subcycle_i < win_end_i);

    // ------------------------------------------------------------
    // Pattern select
    // ------------------------------------------------------------

    always_comb begin
        case (pat_sel_i)
            PAT_LOW:      pin_d = 1'b0;
            PAT_HIGH_WIN: pin_d = in_win;
            PAT_DATA:     pin_d = data_bit_i;               // Ignores window
            PAT_DATA_WIN: pin_d = data_bit_i && in_win;
            default:      pin_d = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_q <= 1'b0;
        end else begin
            dout_q <= en_i ? pin_d : 1'b0;  // Disabled pin driven low
        end
    end

    // One clock behind the subcycle count
    assign dout_o = dout_q;

endmodule

// ==== logic/wfg_pkg.sv ====
`include "wfg_cfg.svh"

package wfg_pkg;

    // ------------------------------------------------------------
    // Width types
    // ------------------------------------------------------------

    typedef logic [`WFG_SUB_W-1:0]      subcycle_t;   // Subcycle number
    typedef logic [`WFG_SUB_W-1:0]      sub_len_t;    // Clocks per subcycle minus one
    typedef logic [`WFG_CHANNELS-1:0]   chan_vec_t;   // One bit per channel
    typedef logic [`WFG_AXIS_WIDTH-1:0] axis_data_t;  // Stream word

    // ------------------------------------------------------------
    // Pattern select codes
    // ------------------------------------------------------------

    typedef logic [`WFG_PAT_SEL_W-1:0] pat_sel_t;

    localparam pat_sel_t PAT_LOW      = 2'd0;  // Pin held low
    localparam pat_sel_t PAT_HIGH_WIN = 2'd1;  // High inside window
    localparam pat_sel_t PAT_DATA     = 2'd2;  // Data bit, whole period
    localparam pat_sel_t PAT_DATA_WIN = 2'd3;  // Data bit inside window, else low

    // Index k selects channel k
    typedef pat_sel_t [`WFG_CHANNELS-1:0] pat_sel_vec_t;

    // Timing core control
    typedef enum logic {
        CORE_IDLE = 1'b0,
        CORE_RUN  = 1'b1
    } core_state_e;

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------

    // Core to driver
    typedef struct packed {
        logic      sync;          // First clock of a period
        subcycle_t subcycle_cnt;  // Current subcycle
    } wfg_timing_t;

    typedef struct packed {
        logic      en;        // Run request
        sub_len_t  sub_len;   // Subcycle length minus one
        subcycle_t last_sub;  // Last subcycle of a period
    } wfg_core_cfg_t;

    typedef struct packed {
        chan_vec_t    ctrl_en;    // Pin enables
        pat_sel_vec_t patsel;     // Per-channel pattern code
        subcycle_t    win_begin;  // First subcycle inside window
        subcycle_t    win_end;    // First subcycle past window
    } wfg_pat_cfg_t;

    // Source side of the stream, tready goes back separately
    typedef struct packed {
        logic       tvalid;
        axis_data_t tdata;
    } axis_in_t;

endpackage

// ==== logic/wfg_top.sv ====
`timescale 1ns/1ps

module wfg_top (
    input  logic                   clk,            // System clock
    input  logic                   rst_n,          // Async reset, active low
    input  wfg_pkg::wfg_core_cfg_t core_cfg_i,     // Timing core setup
    input  wfg_pkg::wfg_pat_cfg_t  pat_cfg_i,      // Pattern driver setup
    input  wfg_pkg::axis_in_t      axis_i,         // Stream from source
    output logic                   axis_tready_o,  // Stream ready, sync cycle only
    output wfg_pkg::chan_vec_t     pat_dout_o,     // Pin levels
    output wfg_pkg::chan_vec_t     pat_dout_en_o   // Pin enables
);

    import wfg_pkg::*;

    // ------------------------------------------------------------
    // Core to driver
    // ------------------------------------------------------------

    wfg_timing_t timing;  // Sync and subcycle number

    // Period and subcycle generation
    wfg_core core_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_i    (core_cfg_i),
        .timing_o (timing)
    );

    // ------------------------------------------------------------
    // Pattern output
    // ------------------------------------------------------------

    // Word capture and per-pin patterns
    wfg_drive_pat drive_pat_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .timing_i      (timing),
        .pat_cfg_i     (pat_cfg_i),
        .axis_i        (axis_i),
        .axis_tready_o (axis_tready_o),
        .pat_dout_o    (pat_dout_o),
        .pat_dout_en_o (pat_dout_en_o)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,    // 10 ns system clock
    output logic rst_n_o   // Active low, 4 cycles
);

    // ------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset held over the first four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;  // Released off the edge
    end

endmodule

// ==== tests/tb_wfg_top.sv ====
`timescale 1ns/1ps

module tb_wfg_top;

    import wfg_pkg::*;

    localparam int MAX_CASES = 32;

    logic          clk;
    logic          rst_n;
    wfg_core_cfg_t core_cfg;
    wfg_pat_cfg_t  pat_cfg;
    axis_in_t      axis;
    logic          axis_tready;
    chan_vec_t     pat_dout;
    chan_vec_t     pat_dout_en;

    // ------------------------------------------------------------
    // Case table, filled from the case file
    // ------------------------------------------------------------

    string         case_name  [MAX_CASES];
    wfg_core_cfg_t case_core  [MAX_CASES];
    wfg_pat_cfg_t  case_pat   [MAX_CASES];
    axis_in_t      case_beat0 [MAX_CASES];  // Offered at the first sync
    axis_in_t      case_beat1 [MAX_CASES];  // Offered at the second sync
    int            case_base  [MAX_CASES];  // Index of first expected vector
    chan_vec_t     exp_pins [$];            // All expected vectors, flat
    int            num_cases;

    int cycle_cnt   = 0;
    int cycle_limit = 0;
    int err_cnt     = 0;

    tb_clock_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    wfg_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_cfg_i    (core_cfg),
        .pat_cfg_i     (pat_cfg),
        .axis_i        (axis),
        .axis_tready_o (axis_tready),
        .pat_dout_o    (pat_dout),
        .pat_dout_en_o (pat_dout_en)
    );

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("Some tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic check_dout(input string tname, input chan_vec_t exp, input chan_vec_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", tname, exp, act);
            err_cnt++;
            $display("Some tests failed");
            $fatal(1, "pin vector check failed");
        end
    endtask

    task automatic check_ready(input string tname, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s: expected ready %b, actual %b", tname, exp, act);
            err_cnt++;
            $display("Some tests failed");
            $fatal(1, "ready check failed");
        end
    endtask

    // Stop on a broken case file
    task automatic file_error(input string what);
        $display("Case file problem, %s", what);
        $display("Some tests failed");
        $fatal(1, "bad case file");
    endtask

    // ------------------------------------------------------------
    // Case file reader
    // ------------------------------------------------------------

    task automatic load_cases();
        int               fd;
        int               r;
        int               i;
        int               n_exp;
        logic [8*32-1:0]  tok;
        logic [8*200-1:0] rest;
        sub_len_t         sl;
        subcycle_t        ls;
        subcycle_t        wb;
        subcycle_t        we;
        chan_vec_t        en_v;
        chan_vec_t        pins;
        pat_sel_vec_t     ps;
        axis_data_t       w0;
        axis_data_t       w1;
        logic             v0;
        logic             v1;

        fd = $fopen("tests/wfg_cases.txt", "r");
        if (fd == 0) begin
            file_error("tests/wfg_cases.txt cannot be opened");
        end
        num_cases = 0;
        tok = '0;
        r = $fscanf(fd, "%s", tok);
        while (r == 1) begin
            if (tok[8*32-1:8] == '0 && tok[7:0] == "#") begin
                r = $fgets(rest, fd);  // Rest of a comment line
            end else begin
                r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
                            sl, ls, wb, we, en_v, ps, w0, v0, w1, v1);
                if (r != 10) begin
                    file_error("a case line has too few fields");
                end
                if (num_cases >= MAX_CASES) begin
                    file_error("more cases than the table holds");
                end
                case_name[num_cases]            = $sformatf("%0s", tok);
                case_core[num_cases].en         = 1'b0;
                case_core[num_cases].sub_len    = sl;
                case_core[num_cases].last_sub   = ls;
                case_pat[num_cases].ctrl_en     = en_v;
                case_pat[num_cases].patsel      = ps;
                case_pat[num_cases].win_begin   = wb;
                case_pat[num_cases].win_end     = we;
                case_beat0[num_cases].tvalid    = v0;
                case_beat0[num_cases].tdata     = w0;
                case_beat1[num_cases].tvalid    = v1;
                case_beat1[num_cases].tdata     = w1;
                case_base[num_cases]            = exp_pins.size();
                n_exp = 2 * (int'(ls) + 1);  // Two periods
                for (i = 0; i < n_exp; i++) begin
                    r = $fscanf(fd, "%h", pins);
                    if (r != 1) begin
                        file_error("a case line has too few expected vectors");
                    end
                    exp_pins.push_back(pins);
                end
                cycle_limit += n_exp * (int'(sl) + 1) + 100;
                num_cases++;
            end
            tok = '0;
            r = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
        if (num_cases == 0) begin
            file_error("no cases were found");
        end
    endtask

    // ------------------------------------------------------------
    // One case, two full periods
    // ------------------------------------------------------------

    task automatic run_case(input int c);
        int        idle_n;
        int        sub_clks;    // Clocks per subcycle
        int        per_clks;    // Clocks per period
        int        since_sync;  // Clocks since the last ready
        int        t;
        chan_vec_t exp_v;
        string     tname;

        tname    = case_name[c];
        sub_clks = int'(case_core[c].sub_len) + 1;
        per_clks = (int'(case_core[c].last_sub) + 1) * sub_clks;

        @(posedge clk);
        #1;
        core_cfg    = case_core[c];  // en still low
        pat_cfg     = case_pat[c];
        axis.tvalid = 1'b0;
        idle_n      = $urandom % 5 + 1;
        repeat (idle_n) begin
            @(negedge clk);
            check_ready(tname, 1'b0, axis_tready);  // No sync while idle
            check_dout(tname, pat_cfg.ctrl_en, pat_dout_en);
        end

        @(posedge clk);
        #1;
        core_cfg.en = 1'b1;
        axis        = case_beat0[c];
        @(negedge clk);
        while (axis_tready !== 1'b1) begin
            check_dout(tname, pat_cfg.ctrl_en, pat_dout_en);
            @(negedge clk);
        end

        since_sync = 0;
        for (t = 0; t <= 2 * per_clks; t++) begin
            if (t > 0) begin
                @(posedge clk);
                #1;
                if (t == 1) begin
                    axis = case_beat1[c];  // Waits for the second sync
                end
                if (t == per_clks + 1) begin
                    axis.tvalid = 1'b0;
                end
                @(negedge clk);
                since_sync++;
            end
            // One ready per period and a full period apart
            check_ready(tname, (t == 0) || (since_sync == per_clks), axis_tready);
            if (axis_tready) begin
                since_sync = 0;
            end
            check_dout(tname, pat_cfg.ctrl_en, pat_dout_en);
            check_dout(tname, '0, pat_dout & ~pat_cfg.ctrl_en);  // Disabled pins low
            if (t < 2 * per_clks && t % sub_clks == sub_clks - 1) begin
                exp_v = exp_pins[case_base[c] + t / sub_clks];  // Last clock of subcycle
                check_dout(tname, exp_v, pat_dout);
            end
        end

        @(posedge clk);
        #1;
        core_cfg.en = 1'b0;
        // Core back in idle, so the next period start never comes
        repeat (per_clks + 1) begin
            @(negedge clk);
            check_ready(tname, 1'b0, axis_tready);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(92));
        core_cfg        = '0;
        pat_cfg         = '0;
        pat_cfg.ctrl_en = 8'hff;  // All enabled and all codes low
        axis            = '0;
        load_cases();

        @(negedge clk);
        while (rst_n !== 1'b1) begin
            check_ready("reset", 1'b0, axis_tready);
            check_dout("reset", '0, pat_dout);
            check_dout("reset", pat_cfg.ctrl_en, pat_dout_en);
            @(negedge clk);
        end
        repeat (3) begin
            check_ready("idle", 1'b0, axis_tready);
            check_dout("idle", '0, pat_dout);
            check_dout("idle", pat_cfg.ctrl_en, pat_dout_en);
            @(negedge clk);
        end

        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end

        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tests/wfg_cases.txt ====
# name sub_len last_sub win_begin win_end ctrl_en patsel word0 valid0 word1 valid1
# then pins in hex at the last clock of each subcycle, period 0 then period 1
all_low    1 3 1 3 ff 0000 deadbeef 1 12345678 1  00 00 00 00  00 00 00 00
high_win   1 3 1 3 ff 5555 00000000 1 ffffffff 1  00 ff ff 00  00 ff ff 00
data_full  2 3 0 0 ff aaaa 000000a5 1 0000003c 1  a5 a5 a5 a5  3c 3c 3c 3c
data_win   1 4 2 4 ff ffff 000000f0 1 0000000f 1  00 00 f0 f0 00  00 00 0f 0f 00
empty_win  1 3 2 1 ff 5f5f ffffffff 1 ffffffff 1  00 00 00 00  00 00 00 00
word_hold  1 3 0 4 ff aaaa 00000069 1 00000096 0  69 69 69 69  69 69 69 69
chan_en    3 2 0 2 33 aaaa 000000ff 1 0000005a 1  33 33 33  12 12 12
mixed      1 3 1 3 ff e4e4 000000ff 1 000000aa 1  44 ee ee 44  00 aa aa 00
mixed_en   2 3 1 4 5a e4e4 000000ff 1 00000000 1  40 4a 4a 4a  00 02 02 02
win_edge   1 5 4 6 ff 5555 00000000 1 00000000 1  00 00 00 00 ff ff  00 00 00 00 ff ff
upper_bits 1 2 0 3 ff aaaa ffffff00 1 0000ff81 1  00 00 00  81 81 81
long_sub   4 1 1 2 f0 ffff 000000cc 1 00000033 1  00 c0  00 30

// ==== wfg_pattern.f ====
+incdir+include
logic/wfg_pkg.sv
logic/wfg_core.sv
logic/wfg_drive_pat_channel.sv
logic/wfg_drive_pat.sv
logic/wfg_top.sv
tests/tb_clock_gen.sv
tests/tb_wfg_top.sv
